// File: Bender.yml
package:
  name: cc_offload_fabric

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cc_pkg.sv
      - rtl/cc_spill_register.sv
      - rtl/cc_offload_router.sv
      - rtl/cc_offload_fabric.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_cc_offload_fabric.sv

// File: flist.f
+incdir+rtl
rtl/cc_pkg.sv
rtl/cc_spill_register.sv
rtl/cc_offload_router.sv
rtl/cc_offload_fabric.sv
testbench/tb_cc_offload_fabric.sv

// File: rtl/cc_offload_fabric.sv
/*
 * Offload fabric top: spill cuts on the offload and TCDM paths
 * around the request router and response arbiter
 */
`timescale 1ns/1ps
`default_nettype none

`include "cc_params.svh"

module cc_offload_fabric (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Core offload port
  input  cc_pkg::acc_req_t                       acc_req_i,
  input  logic                                   acc_req_valid_i,
  output logic                                   acc_req_ready_o,
  output cc_pkg::acc_resp_t                      acc_resp_o,
  output logic                                   acc_resp_valid_o,
  input  logic                                   acc_resp_ready_i,
  // Offload unit ports
  output cc_pkg::acc_req_t                       unit_req_o,
  output logic [`CC_NUM_UNITS-1:0]               unit_req_valid_o,
  input  logic [`CC_NUM_UNITS-1:0]               unit_req_ready_i,
  input  cc_pkg::acc_resp_t [`CC_NUM_UNITS-1:0]  unit_resp_i,
  input  logic [`CC_NUM_UNITS-1:0]               unit_resp_valid_i,
  output logic [`CC_NUM_UNITS-1:0]               unit_resp_ready_o,
  // Core TCDM port
  input  cc_pkg::dreq_t                          core_dreq_i,
  input  logic                                   core_dreq_valid_i,
  output logic                                   core_dreq_ready_o,
  output cc_pkg::dresp_t                         core_dresp_o,
  output logic                                   core_dresp_valid_o,
  input  logic                                   core_dresp_ready_i,
  // Memory TCDM port
  output cc_pkg::dreq_t                          mem_dreq_o,
  output logic                                   mem_dreq_valid_o,
  input  logic                                   mem_dreq_ready_i,
  input  cc_pkg::dresp_t                         mem_dresp_i,
  input  logic                                   mem_dresp_valid_i,
  output logic                                   mem_dresp_ready_o
);

  import cc_pkg::*;

  // Between the cuts and the router
  acc_req_t  acc_req_q;
  logic      acc_req_q_valid, acc_req_q_ready;
  acc_resp_t acc_resp_d;
  logic      acc_resp_d_valid, acc_resp_d_ready;

  // ------------------------------------------------------------
  // Offload path
  // ------------------------------------------------------------
  cc_spill_register #(
    .T      (acc_req_t),
    .Bypass (!`CC_REG_OFFLOAD_REQ)
  ) u_acc_req_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (acc_req_valid_i),
    .ready_o (acc_req_ready_o),
    .data_i  (acc_req_i),
    .valid_o (acc_req_q_valid),
    .ready_i (acc_req_q_ready),
    .data_o  (acc_req_q)
  );

  cc_offload_router u_router (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req_i             (acc_req_q),
    .req_valid_i       (acc_req_q_valid),
    .req_ready_o       (acc_req_q_ready),
    .unit_req_o        (unit_req_o),
    .unit_req_valid_o  (unit_req_valid_o),
    .unit_req_ready_i  (unit_req_ready_i),
    .unit_resp_i       (unit_resp_i),
    .unit_resp_valid_i (unit_resp_valid_i),
    .unit_resp_ready_o (unit_resp_ready_o),
    .resp_o            (acc_resp_d),
    .resp_valid_o      (acc_resp_d_valid),
    .resp_ready_i      (acc_resp_d_ready)
  );

  cc_spill_register #(
    .T      (acc_resp_t),
    .Bypass (!`CC_REG_OFFLOAD_RESP)
  ) u_acc_resp_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (acc_resp_d_valid),
    .ready_o (acc_resp_d_ready),
    .data_i  (acc_resp_d),
    .valid_o (acc_resp_valid_o),
    .ready_i (acc_resp_ready_i),
    .data_o  (acc_resp_o)
  );

  // ------------------------------------------------------------
  // TCDM path, valid taken from the registered side
  // ------------------------------------------------------------
  cc_spill_register #(
    .T      (dreq_t),
    .Bypass (!`CC_REG_TCDM_REQ)
  ) u_tcdm_req_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (core_dreq_valid_i),
    .ready_o (core_dreq_ready_o),
    .data_i  (core_dreq_i),
    .valid_o (mem_dreq_valid_o),
    .ready_i (mem_dreq_ready_i),
    .data_o  (mem_dreq_o)
  );

  cc_spill_register #(
    .T      (dresp_t),
    .Bypass (!`CC_REG_TCDM_RESP)
  ) u_tcdm_resp_cut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mem_dresp_valid_i),
    .ready_o (mem_dresp_ready_o),
    .data_i  (mem_dresp_i),
    .valid_o (core_dresp_valid_o),
    .ready_i (core_dresp_ready_i),
    .data_o  (core_dresp_o)
  );

endmodule

`default_nettype wire

// File: rtl/cc_offload_router.sv
/*
 * Offload router that steers core requests to one unit by address select bits
 * and merges unit responses with a round-robin arbiter
 */
`timescale 1ns/1ps
`default_nettype none

`include "cc_params.svh"

module cc_offload_router (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // Core side request
  input  cc_pkg::acc_req_t                       req_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  // Unit side request with the struct broadcast to all units
  output cc_pkg::acc_req_t                       unit_req_o,
  output logic [`CC_NUM_UNITS-1:0]               unit_req_valid_o,
  input  logic [`CC_NUM_UNITS-1:0]               unit_req_ready_i,
  // Unit side response
  input  cc_pkg::acc_resp_t [`CC_NUM_UNITS-1:0]  unit_resp_i,
  input  logic [`CC_NUM_UNITS-1:0]               unit_resp_valid_i,
  output logic [`CC_NUM_UNITS-1:0]               unit_resp_ready_o,
  // Core side response
  output cc_pkg::acc_resp_t                      resp_o,
  output logic                                   resp_valid_o,
  input  logic                                   resp_ready_i
);

  import cc_pkg::*;

  // ------------------------------------------------------------
  // Request demux
  // ------------------------------------------------------------
  offload_unit_e req_sel;
  logic          req_sel_ok;

  assign req_sel    = offload_unit_e'(req_i.addr[`CC_SEL_W-1:0]);
  assign req_sel_ok = int'(req_sel) < `CC_NUM_UNITS;
  assign unit_req_o = req_i;

  always_comb begin
    unit_req_valid_o = '0;
    req_ready_o      = 1'b0;
    if (req_sel_ok) begin
      unit_req_valid_o[req_sel] = req_valid_i;
      req_ready_o               = unit_req_ready_i[req_sel];
    end
  end

  // ------------------------------------------------------------
  // Response round-robin arbiter
  // ------------------------------------------------------------
  offload_unit_e rr_q, rr_d;
  offload_unit_e gnt_q, rr_gnt, gnt_unit;
  logic          lock_q, lock_d;

  // First valid unit at or after the pointer
  always_comb begin : rr_search
    logic        found;
    int unsigned idx;
    found  = 1'b0;
    rr_gnt = rr_q;
    for (int unsigned i = 0; i < `CC_NUM_UNITS; i++) begin
      idx = int'(rr_q) + i;
      if (idx >= `CC_NUM_UNITS) begin
        idx = idx - `CC_NUM_UNITS;
      end
      if (!found && unit_resp_valid_i[idx]) begin
        found  = 1'b1;
        rr_gnt = offload_unit_e'(idx[`CC_SEL_W-1:0]);
      end
    end
  end

  // Granted unit keeps its valid up until the transfer
  assign gnt_unit     = lock_q ? gnt_q : rr_gnt;
  assign resp_valid_o = unit_resp_valid_i[gnt_unit];
  assign resp_o       = unit_resp_i[gnt_unit];

  always_comb begin
    unit_resp_ready_o           = '0;
    unit_resp_ready_o[gnt_unit] = resp_valid_o && resp_ready_i;
  end

  always_comb begin
    rr_d   = rr_q;
    lock_d = resp_valid_o && !resp_ready_i;
    if (resp_valid_o && resp_ready_i) begin
      if (int'(gnt_unit) == `CC_NUM_UNITS - 1) begin
        rr_d = UNIT_IPU;
      end else begin
        rr_d = offload_unit_e'(gnt_unit + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_q   <= UNIT_IPU;
      gnt_q  <= UNIT_IPU;
      lock_q <= 1'b0;
    end else begin
      rr_q   <= rr_d;
      gnt_q  <= gnt_unit;
      lock_q <= lock_d;
    end
  end

  // Select value 3 has no unit behind it
  req_sel_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> req_sel_ok
  );

  // A pending unit request stays on its unit until taken
  req_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    |unit_req_valid_o && !req_ready_o |=> $stable(unit_req_valid_o) && $stable(unit_req_o)
  );

endmodule

`default_nettype wire

// File: rtl/cc_params.svh
/*
 * Offload fabric widths, unit count and pipeline cut switches
 */
`ifndef CC_PARAMS_SVH
`define CC_PARAMS_SVH

// Payload widths
`define CC_ADDR_W 32
`define CC_DATA_W 32
`define CC_ID_W   5
`define CC_STRB_W 4
`define CC_AMO_W  4

// Offload units, selected by the low address bits
`define CC_NUM_UNITS 3
`define CC_SEL_W     2

// Spill register cuts, 1 inserts a register stage
`define CC_REG_OFFLOAD_REQ  1'b1
`define CC_REG_OFFLOAD_RESP 1'b1
`define CC_REG_TCDM_REQ     1'b0
`define CC_REG_TCDM_RESP    1'b0

`endif

// File: rtl/cc_pkg.sv
/*
 * Core complex types: offload and TCDM payload structs, unit and AMO enums
 */
`default_nettype none

`include "cc_params.svh"

package cc_pkg;

  typedef enum logic [`CC_SEL_W-1:0] {
    UNIT_IPU     = 2'd0,
    UNIT_FPU     = 2'd1,
    UNIT_DIVSQRT = 2'd2
  } offload_unit_e;

  // RISC-V A extension operations on the data port
  typedef enum logic [`CC_AMO_W-1:0] {
    AMO_NONE, AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR, AMO_XOR,
    AMO_MAX, AMO_MAXU, AMO_MIN, AMO_MINU, AMO_LR, AMO_SC
  } amo_op_e;

  typedef struct packed {
    logic [`CC_ADDR_W-1:0] addr;
    logic [`CC_ID_W-1:0]   id;
    logic [`CC_DATA_W-1:0] data_op;
    logic [`CC_DATA_W-1:0] data_arga;
    logic [`CC_DATA_W-1:0] data_argb;
    logic [`CC_DATA_W-1:0] data_argc;
  } acc_req_t;

  typedef struct packed {
    logic [`CC_ID_W-1:0]   id;
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
  } acc_resp_t;

  typedef struct packed {
    logic [`CC_ADDR_W-1:0] addr;
    logic                  write;
    amo_op_e               amo;
    logic [`CC_DATA_W-1:0] data;
    logic [`CC_STRB_W-1:0] strb;
    logic [`CC_ID_W-1:0]   id;
  } dreq_t;

  typedef struct packed {
    logic [`CC_DATA_W-1:0] data;
    logic                  error;
    logic [`CC_ID_W-1:0]   id;
  } dresp_t;

endpackage

`default_nettype wire

// File: rtl/cc_spill_register.sv
/*
 * Spill register as a two-slot valid/ready cut that breaks both the
 * forward and the ready path, or plain wires when bypassed
 */
`timescale 1ns/1ps
`default_nettype none

module cc_spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_cut
    // ------------------------------------------------------------
    // Slot A takes new items, slot B catches A on a stall
    // ------------------------------------------------------------
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain;
    logic b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    // A empties downstream or into B whenever B has room
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older item
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;

    // Stalled output keeps its item until taken
    a_out_stable: assert property (
      @(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o)
    );

    // With both slots taken the A item waits untouched
    a_no_overflow: assert property (
      @(posedge clk_i) disable iff (rst_i)
      a_full_q && b_full_q |=> a_full_q && $stable(a_data_q)
    );
  end

endmodule

`default_nettype wire

// File: testbench/tb_cc_offload_fabric.sv
/*
 * Testbench for the offload fabric covering routing, back-pressure,
 * round-robin responses and TCDM pass-through
 */
`timescale 1ns/1ps
`default_nettype none

`include "cc_params.svh"

module tb_cc_offload_fabric;

  import cc_pkg::*;

  // Tests need a few hundred cycles
  localparam int MAX_CYCLES = 5000;
  localparam int RR_COUNT   = 20;
  localparam int BP_COUNT   = 6;

  logic                               clk_i;
  logic                               rst_i;
  acc_req_t                           acc_req_i;
  logic                               acc_req_valid_i;
  logic                               acc_req_ready_o;
  acc_resp_t                          acc_resp_o;
  logic                               acc_resp_valid_o;
  logic                               acc_resp_ready_i;
  acc_req_t                           unit_req_o;
  logic [`CC_NUM_UNITS-1:0]           unit_req_valid_o;
  logic [`CC_NUM_UNITS-1:0]           unit_req_ready_i;
  acc_resp_t [`CC_NUM_UNITS-1:0]      unit_resp_i;
  logic [`CC_NUM_UNITS-1:0]           unit_resp_valid_i;
  logic [`CC_NUM_UNITS-1:0]           unit_resp_ready_o;
  dreq_t                              core_dreq_i;
  logic                               core_dreq_valid_i;
  logic                               core_dreq_ready_o;
  dresp_t                             core_dresp_o;
  logic                               core_dresp_valid_o;
  logic                               core_dresp_ready_i;
  dreq_t                              mem_dreq_o;
  logic                               mem_dreq_valid_o;
  logic                               mem_dreq_ready_i;
  dresp_t                             mem_dresp_i;
  logic                               mem_dresp_valid_i;
  logic                               mem_dresp_ready_o;
  int                                 cycle_cnt;

  cc_offload_fabric dut0 (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .acc_req_i          (acc_req_i),
    .acc_req_valid_i    (acc_req_valid_i),
    .acc_req_ready_o    (acc_req_ready_o),
    .acc_resp_o         (acc_resp_o),
    .acc_resp_valid_o   (acc_resp_valid_o),
    .acc_resp_ready_i   (acc_resp_ready_i),
    .unit_req_o         (unit_req_o),
    .unit_req_valid_o   (unit_req_valid_o),
    .unit_req_ready_i   (unit_req_ready_i),
    .unit_resp_i        (unit_resp_i),
    .unit_resp_valid_i  (unit_resp_valid_i),
    .unit_resp_ready_o  (unit_resp_ready_o),
    .core_dreq_i        (core_dreq_i),
    .core_dreq_valid_i  (core_dreq_valid_i),
    .core_dreq_ready_o  (core_dreq_ready_o),
    .core_dresp_o       (core_dresp_o),
    .core_dresp_valid_o (core_dresp_valid_o),
    .core_dresp_ready_i (core_dresp_ready_i),
    .mem_dreq_o         (mem_dreq_o),
    .mem_dreq_valid_o   (mem_dreq_valid_o),
    .mem_dreq_ready_i   (mem_dreq_ready_i),
    .mem_dresp_i        (mem_dresp_i),
    .mem_dresp_valid_i  (mem_dresp_valid_i),
    .mem_dresp_ready_o  (mem_dresp_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopping at first error");
  endtask

  function automatic acc_req_t rand_acc_req(input int unsigned sel);
    acc_req_t r;
    r.addr                = $urandom();
    r.addr[`CC_SEL_W-1:0] = `CC_SEL_W'(sel);
    r.id                  = `CC_ID_W'($urandom());
    r.data_op             = $urandom();
    r.data_arga           = $urandom();
    r.data_argb           = $urandom();
    r.data_argc           = $urandom();
    return r;
  endfunction

  function automatic acc_resp_t rand_acc_resp();
    acc_resp_t r;
    r.id    = `CC_ID_W'($urandom());
    r.data  = $urandom();
    r.error = 1'($urandom_range(0, 1));
    return r;
  endfunction

  function automatic dreq_t rand_dreq();
    dreq_t r;
    r.addr  = $urandom();
    r.write = 1'($urandom_range(0, 1));
    r.amo   = amo_op_e'($urandom_range(0, int'(AMO_SC)));
    r.data  = $urandom();
    r.strb  = `CC_STRB_W'($urandom());
    r.id    = `CC_ID_W'($urandom());
    return r;
  endfunction

  function automatic dresp_t rand_dresp();
    dresp_t r;
    r.data  = $urandom();
    r.error = 1'($urandom_range(0, 1));
    r.id    = `CC_ID_W'($urandom());
    return r;
  endfunction

  task automatic check_idle(input string phase);
    assert (!acc_resp_valid_o && unit_req_valid_o == '0 && !mem_dreq_valid_o)
      else report_mismatch($sformatf("valid outputs not idle %s", phase));
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_state();
    rst_i = 1'b1;
    // First rising edge clears the flops
    @(posedge clk_i);
    repeat (10) begin
      @(negedge clk_i);
      check_idle("during reset");
    end
    rst_i = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      check_idle("after reset");
    end
  endtask

  task automatic request_routing();
    acc_req_t req;
    unit_req_ready_i = '1;
    for (int sel = 0; sel < `CC_NUM_UNITS; sel++) begin
      repeat (6) begin
        req = rand_acc_req(sel);
        @(negedge clk_i);
        acc_req_i       = req;
        acc_req_valid_i = 1'b1;
        @(posedge clk_i);
        while (!acc_req_ready_o) @(posedge clk_i);
        assert (unit_req_valid_o == '0)
          else report_mismatch("unit valid high before the request was accepted");
        @(negedge clk_i);
        acc_req_valid_i = 1'b0;
        // One cycle after acceptance
        @(posedge clk_i);
        assert (unit_req_valid_o == (`CC_NUM_UNITS'(1) << sel))
          else report_mismatch($sformatf("unit_req_valid_o %b for select %0d",
                                         unit_req_valid_o, sel));
        assert (unit_req_o == req)
          else report_mismatch($sformatf("unit_req_o %h, expected %h", unit_req_o, req));
      end
    end
  endtask

  task automatic request_backpressure();
    acc_req_t    reqs [BP_COUNT];
    int unsigned sel;
    int          sent;
    int          got;
    int          cyc;
    sel  = $urandom_range(0, `CC_NUM_UNITS - 1);
    sent = 0;
    got  = 0;
    cyc  = 0;
    for (int i = 0; i < BP_COUNT; i++) begin
      reqs[i] = rand_acc_req(sel);
    end
    while (got < BP_COUNT) begin
      @(negedge clk_i);
      acc_req_valid_i = sent < BP_COUNT;
      if (sent < BP_COUNT) begin
        acc_req_i = reqs[sent];
      end
      // Unit stalls for the first six cycles
      unit_req_ready_i = (cyc >= 6) ? '1 : '0;
      @(posedge clk_i);
      if (cyc < 6 && sent >= 2) begin
        assert (!acc_req_ready_o)
          else report_mismatch("acc_req_ready_o high with two requests held");
      end
      assert ((unit_req_valid_o & ~(`CC_NUM_UNITS'(1) << sel)) == '0)
        else report_mismatch($sformatf("unselected unit valid, %b", unit_req_valid_o));
      if (unit_req_valid_o[sel] && unit_req_ready_i[sel]) begin
        assert (unit_req_o == reqs[got])
          else report_mismatch($sformatf("request %0d is %h, expected %h",
                                         got, unit_req_o, reqs[got]));
        got++;
      end
      if (acc_req_valid_i && acc_req_ready_o) begin
        sent++;
      end
      cyc++;
      if (cyc == 6) begin
        assert (sent == 2)
          else report_mismatch($sformatf("%0d requests accepted under stall", sent));
      end
    end
    @(negedge clk_i);
    acc_req_valid_i  = 1'b0;
    unit_req_ready_i = '1;
  endtask

  task automatic response_round_robin(input bit stall);
    acc_resp_t rsp [`CC_NUM_UNITS][RR_COUNT];
    acc_resp_t exp_q [$];
    acc_resp_t exp_rsp;
    int        head [`CC_NUM_UNITS];
    int        got;
    int        cycles;
    // Expected order rotates IPU, FPU, DIVSQRT
    for (int k = 0; k < RR_COUNT; k++) begin
      for (int u = 0; u < `CC_NUM_UNITS; u++) begin
        rsp[u][k] = rand_acc_resp();
        exp_q.push_back(rsp[u][k]);
      end
    end
    for (int u = 0; u < `CC_NUM_UNITS; u++) begin
      head[u] = 0;
    end
    got    = 0;
    cycles = 0;
    while (got < `CC_NUM_UNITS * RR_COUNT) begin
      @(negedge clk_i);
      for (int u = 0; u < `CC_NUM_UNITS; u++) begin
        if (head[u] < RR_COUNT) begin
          unit_resp_valid_i[u] = 1'b1;
          unit_resp_i[u]       = rsp[u][head[u]];
        end else begin
          unit_resp_valid_i[u] = 1'b0;
        end
      end
      acc_resp_ready_i = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
      @(posedge clk_i);
      cycles++;
      for (int u = 0; u < `CC_NUM_UNITS; u++) begin
        if (unit_resp_valid_i[u] && unit_resp_ready_o[u]) begin
          head[u]++;
        end
      end
      if (acc_resp_valid_o && acc_resp_ready_i) begin
        exp_rsp = exp_q.pop_front();
        assert (acc_resp_o == exp_rsp)
          else report_mismatch($sformatf("response %0d is %h, expected %h",
                                         got, acc_resp_o, exp_rsp));
        got++;
      end
    end
    // One cycle latency and then one response per cycle
    if (!stall) begin
      assert (cycles == `CC_NUM_UNITS * RR_COUNT + 1)
        else report_mismatch($sformatf("responses took %0d cycles", cycles));
    end
    @(negedge clk_i);
    unit_resp_valid_i = '0;
    acc_resp_ready_i  = 1'b1;
    @(posedge clk_i);
    assert (!acc_resp_valid_o)
      else report_mismatch("extra response after all were delivered");
  endtask

  task automatic tcdm_passthrough();
    for (int i = 0; i < 80; i++) begin
      @(negedge clk_i);
      // Stalled items stay put until taken
      if (!(core_dreq_valid_i && !mem_dreq_ready_i)) begin
        core_dreq_valid_i = 1'($urandom_range(0, 1));
        core_dreq_i       = rand_dreq();
      end
      if (!(mem_dresp_valid_i && !core_dresp_ready_i)) begin
        mem_dresp_valid_i = 1'($urandom_range(0, 1));
        mem_dresp_i       = rand_dresp();
      end
      mem_dreq_ready_i   = 1'($urandom_range(0, 1));
      core_dresp_ready_i = 1'($urandom_range(0, 1));
      @(posedge clk_i);
      assert (mem_dreq_valid_o == core_dreq_valid_i && mem_dreq_o == core_dreq_i)
        else report_mismatch($sformatf("mem_dreq_o %h, expected %h", mem_dreq_o, core_dreq_i));
      assert (core_dreq_ready_o == mem_dreq_ready_i)
        else report_mismatch("core_dreq_ready_o does not follow mem_dreq_ready_i");
      assert (core_dresp_valid_o == mem_dresp_valid_i && core_dresp_o == mem_dresp_i)
        else report_mismatch($sformatf("core_dresp_o %h, expected %h",
                                       core_dresp_o, mem_dresp_i));
      assert (mem_dresp_ready_o == core_dresp_ready_i)
        else report_mismatch("mem_dresp_ready_o does not follow core_dresp_ready_i");
    end
    @(negedge clk_i);
    core_dreq_valid_i = 1'b0;
    mem_dresp_valid_i = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(51));
    cycle_cnt          = 0;
    rst_i              = 1'b1;
    acc_req_i          = '0;
    acc_req_valid_i    = 1'b0;
    acc_resp_ready_i   = 1'b1;
    unit_req_ready_i   = '1;
    unit_resp_i        = '0;
    unit_resp_valid_i  = '0;
    core_dreq_i        = '0;
    core_dreq_valid_i  = 1'b0;
    core_dresp_ready_i = 1'b1;
    mem_dreq_ready_i   = 1'b1;
    mem_dresp_i        = '0;
    mem_dresp_valid_i  = 1'b0;

    reset_state();
    request_routing();
    request_backpressure();
    response_round_robin(1'b0);
    response_round_robin(1'b1);
    tcdm_passthrough();

    repeat (2) @(negedge clk_i);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
